// ==== exu_pkg.sv ====
package exu_pkg;

  localparam int OP_W      = 5;
  localparam int REG_IDX_W = 5;
  // writeback data width, fixed by the record layout
  localparam int WB_DATA_W = 64;

  // micro-op codes, 20 to 31 are unused and decode as illegal
  typedef enum logic [OP_W-1:0] {
    OP_ADD    = 5'd0,
    OP_SUB    = 5'd1,
    OP_SLL    = 5'd2,
    OP_SLT    = 5'd3,
    OP_SLTU   = 5'd4,
    OP_XOR    = 5'd5,
    OP_SRL    = 5'd6,
    OP_SRA    = 5'd7,
    OP_OR     = 5'd8,
    OP_AND    = 5'd9,
    OP_LUI    = 5'd10,
    OP_JAL    = 5'd11,
    OP_JALR   = 5'd12,
    OP_BEQ    = 5'd13,
    OP_BNE    = 5'd14,
    OP_BLT    = 5'd15,
    OP_BGE    = 5'd16,
    OP_BLTU   = 5'd17,
    OP_BGEU   = 5'd18,
    OP_EBREAK = 5'd19
  } exu_op_e;

  // which unit owns an op code
  typedef enum logic [1:0] {
    UNIT_ALU = 2'd0,
    UNIT_BJP = 2'd1,
    UNIT_SYS = 2'd2,
    UNIT_BAD = 2'd3
  } exu_unit_e;

  typedef enum logic [1:0] {
    TRAP_NONE    = 2'd0,
    TRAP_EBREAK  = 2'd1,
    TRAP_ILLEGAL = 2'd2
  } exu_trap_e;

  typedef struct packed {
    logic                 rd_wr_en;
    logic [REG_IDX_W-1:0] rd_idx;
    logic [WB_DATA_W-1:0] rd_data;
  } exu_wb_t;

  function automatic exu_unit_e op_unit(logic [OP_W-1:0] op);
    if (op <= OP_LUI) return UNIT_ALU;
    if (op <= OP_BGEU) return UNIT_BJP;
    if (op == OP_EBREAK) return UNIT_SYS;
    return UNIT_BAD;
  endfunction

  // conditional branches only, jal/jalr excluded
  function automatic logic is_cond_br(logic [OP_W-1:0] op);
    return (op >= OP_BEQ) && (op <= OP_BGEU);
  endfunction

endpackage

// ==== exu_alu.sv ====
`timescale 1ns/100ps

module exu_alu #(
  parameter int XLEN = 64
) (
  input  exu_pkg::exu_op_e  op_i,
  input  logic [XLEN-1:0]   op1_i,
  input  logic [XLEN-1:0]   op2_i,
  output logic [XLEN-1:0]   alu_res_o
);

  localparam int SHAMT_W = $clog2(XLEN);

  logic              is_sub;
  logic              ext1;
  logic              ext2;
  logic [XLEN:0]     add_a;
  logic [XLEN:0]     add_b;
  logic [XLEN:0]     adder_res;
  logic [SHAMT_W-1:0] shamt;
  logic [XLEN-1:0]   sll_res;
  logic [XLEN-1:0]   srl_res;
  logic [XLEN-1:0]   sra_res;
  logic [XLEN-1:0]   lt_res;

  // slt and sltu share the subtractor
  assign is_sub = (op_i == exu_pkg::OP_SUB) ||
                  (op_i == exu_pkg::OP_SLT) ||
                  (op_i == exu_pkg::OP_SLTU);

  // zero extension for sltu, sign extension otherwise
  assign ext1 = (op_i == exu_pkg::OP_SLTU) ? 1'b0 : op1_i[XLEN-1];
  assign ext2 = (op_i == exu_pkg::OP_SLTU) ? 1'b0 : op2_i[XLEN-1];

  assign add_a = {ext1, op1_i};
  assign add_b = is_sub ? ~{ext2, op2_i} : {ext2, op2_i};

  // extra top bit holds the sign of op1 - op2
  assign adder_res = add_a + add_b + {{XLEN{1'b0}}, is_sub};

  assign lt_res = {{(XLEN-1){1'b0}}, adder_res[XLEN]};

  assign shamt   = op2_i[SHAMT_W-1:0];
  assign sll_res = op1_i << shamt;
  assign srl_res = op1_i >> shamt;
  assign sra_res = $signed(op1_i) >>> shamt;

  always_comb begin
    case (op_i)
      exu_pkg::OP_ADD,
      exu_pkg::OP_SUB:  alu_res_o = adder_res[XLEN-1:0];
      exu_pkg::OP_SLL:  alu_res_o = sll_res;
      exu_pkg::OP_SLT,
      exu_pkg::OP_SLTU: alu_res_o = lt_res;
      exu_pkg::OP_XOR:  alu_res_o = op1_i ^ op2_i;
      exu_pkg::OP_SRL:  alu_res_o = srl_res;
      exu_pkg::OP_SRA:  alu_res_o = sra_res;
      exu_pkg::OP_OR:   alu_res_o = op1_i | op2_i;
      exu_pkg::OP_AND:  alu_res_o = op1_i & op2_i;
      // decoder places the shifted immediate in op2
      exu_pkg::OP_LUI:  alu_res_o = op2_i;
      // link value, decoder supplies pc and 4
      exu_pkg::OP_JAL,
      exu_pkg::OP_JALR: alu_res_o = adder_res[XLEN-1:0];
      default:          alu_res_o = '0;
    endcase
  end

  // commit relies on a clean zero for conditional branches
  always_comb begin
    if (exu_pkg::is_cond_br(op_i)) begin
      a_br_res_zero: assert (alu_res_o == '0)
        else $error("alu result not zero for branch op %0d", op_i);
    end
  end

endmodule

// ==== exu_bjp.sv ====
`timescale 1ns/100ps

module exu_bjp #(
  parameter int XLEN = 64
) (
  input  exu_pkg::exu_op_e op_i,
  input  logic [XLEN-1:0]  op1_i,
  input  logic [XLEN-1:0]  op2_i,
  input  logic [XLEN-1:0]  op1_jp_i,
  input  logic [XLEN-1:0]  op2_jp_i,
  output logic             jump_flag_o,
  output logic [XLEN-1:0]  jump_addr_o
);

  logic            cmp_eq;
  logic            cmp_lt;
  logic            cmp_ltu;
  logic            is_jalr;
  logic [XLEN-1:0] target_sum;

  // compare results, one of them picked per branch op
  assign cmp_eq  = (op1_i == op2_i);
  assign cmp_lt  = ($signed(op1_i) < $signed(op2_i));
  assign cmp_ltu = (op1_i < op2_i);

  always_comb begin
    case (op_i)
      exu_pkg::OP_JAL,
      exu_pkg::OP_JALR: jump_flag_o = 1'b1;
      exu_pkg::OP_BEQ:  jump_flag_o = cmp_eq;
      exu_pkg::OP_BNE:  jump_flag_o = !cmp_eq;
      exu_pkg::OP_BLT:  jump_flag_o = cmp_lt;
      exu_pkg::OP_BGE:  jump_flag_o = !cmp_lt;
      exu_pkg::OP_BLTU: jump_flag_o = cmp_ltu;
      exu_pkg::OP_BGEU: jump_flag_o = !cmp_ltu;
      default:          jump_flag_o = 1'b0;
    endcase
  end

  // target is pc + offset for branches and jal, rs1 + imm for jalr
  assign target_sum = op1_jp_i + op2_jp_i;
  assign is_jalr    = (op_i == exu_pkg::OP_JALR);

  // jalr drops bit 0 of its target
  assign jump_addr_o = {target_sum[XLEN-1:1], target_sum[0] & !is_jalr};

endmodule

// ==== exu_pipe_reg.sv ====
`timescale 1ns/100ps

module exu_pipe_reg #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic rst_n_i,
  input  logic in_valid_i,
  input  T     in_data_i,
  output logic in_ready_o,
  input  logic out_ready_i,
  output logic out_valid_o,
  output T     out_data_o
);

  logic valid_q;
  logic load;
  T     data_q;

  // accept when empty or when the held item leaves this cycle
  assign in_ready_o = !valid_q || out_ready_i;
  assign load       = in_valid_i && in_ready_o;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (out_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      data_q <= in_data_i;
    end
  end

  assign out_valid_o = valid_q;
  assign out_data_o  = data_q;

  // stalled item stays put until the consumer takes it
  a_hold_stable: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_data_o))
  ) else $error("output changed while stalled");

endmodule

// ==== exu_commit.sv ====
`timescale 1ns/100ps

module exu_commit #(
  parameter int XLEN = 64
) (
  input  logic                              clk,
  input  logic                              rst_n_i,
  input  logic                              valid_i,
  input  exu_pkg::exu_op_e                  op_i,
  input  logic                              rd_wr_en_i,
  input  logic [exu_pkg::REG_IDX_W-1:0]     rd_idx_i,
  input  logic [XLEN-1:0]                   alu_res_i,
  input  logic                              jump_flag_i,
  input  logic [XLEN-1:0]                   jump_addr_i,
  input  logic                              out_ready_i,
  output logic                              ready_o,
  output logic                              out_valid_o,
  output logic                              rd_wr_en_o,
  output logic [exu_pkg::REG_IDX_W-1:0]     rd_idx_o,
  output logic [XLEN-1:0]                   rd_data_o,
  output logic                              redirect_o,
  output logic [XLEN-1:0]                   redirect_addr_o,
  output exu_pkg::exu_trap_e                trap_o
);

  localparam int WB_DW = exu_pkg::WB_DATA_W;

  // writeback record plus redirect and trap side fields
  typedef struct packed {
    exu_pkg::exu_wb_t   wb;
    logic               redirect;
    exu_pkg::exu_trap_e trap;
  } commit_rec_t;

  exu_pkg::exu_unit_e unit;
  exu_pkg::exu_trap_e trap_cause;
  logic               trapped;
  commit_rec_t        rec_in;
  commit_rec_t        rec_q;
  logic               wb_ready;
  logic               wb_valid;
  logic               jp_ready;
  logic               jp_valid;
  logic [XLEN-1:0]    jp_addr_q;

  assign unit = exu_pkg::op_unit(op_i);

  always_comb begin
    case (unit)
      exu_pkg::UNIT_SYS: trap_cause = exu_pkg::TRAP_EBREAK;
      exu_pkg::UNIT_BAD: trap_cause = exu_pkg::TRAP_ILLEGAL;
      default:           trap_cause = exu_pkg::TRAP_NONE;
    endcase
  end

  assign trapped = (trap_cause != exu_pkg::TRAP_NONE);

  // trapped ops still pass through without side effects
  always_comb begin
    rec_in.wb.rd_wr_en = rd_wr_en_i && !trapped && !exu_pkg::is_cond_br(op_i);
    rec_in.wb.rd_idx   = rd_idx_i;
    rec_in.wb.rd_data  = WB_DW'(alu_res_i);
    rec_in.redirect    = jump_flag_i && !trapped;
    rec_in.trap        = trap_cause;
  end

  exu_pipe_reg #(.T(commit_rec_t)) u_wb_reg (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (valid_i),
    .in_data_i   (rec_in),
    .in_ready_o  (wb_ready),
    .out_ready_i (out_ready_i),
    .out_valid_o (wb_valid),
    .out_data_o  (rec_q)
  );

  exu_pipe_reg #(.T(logic [XLEN-1:0])) u_jp_reg (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (valid_i),
    .in_data_i   (jump_addr_i),
    .in_ready_o  (jp_ready),
    .out_ready_i (out_ready_i),
    .out_valid_o (jp_valid),
    .out_data_o  (jp_addr_q)
  );

  assign ready_o     = wb_ready && jp_ready;
  assign out_valid_o = wb_valid && jp_valid;

  // side fields read inactive while empty
  assign rd_wr_en_o      = out_valid_o && rec_q.wb.rd_wr_en;
  assign rd_idx_o        = rec_q.wb.rd_idx;
  assign rd_data_o       = rec_q.wb.rd_data[XLEN-1:0];
  assign redirect_o      = out_valid_o && rec_q.redirect;
  assign redirect_addr_o = jp_addr_q;
  assign trap_o          = out_valid_o ? rec_q.trap : exu_pkg::TRAP_NONE;

endmodule

// ==== exu_top.sv ====
`timescale 1ns/100ps

module exu_top #(
  parameter int XLEN = 64
) (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  logic                          valid_i,
  output logic                          ready_o,
  input  exu_pkg::exu_op_e              op_i,
  input  logic                          rd_wr_en_i,
  input  logic [exu_pkg::REG_IDX_W-1:0] rd_idx_i,
  input  logic [XLEN-1:0]               op1_i,
  input  logic [XLEN-1:0]               op2_i,
  input  logic [XLEN-1:0]               op1_jp_i,
  input  logic [XLEN-1:0]               op2_jp_i,
  input  logic                          out_ready_i,
  output logic                          out_valid_o,
  output logic                          rd_wr_en_o,
  output logic [exu_pkg::REG_IDX_W-1:0] rd_idx_o,
  output logic [XLEN-1:0]               rd_data_o,
  output logic                          redirect_o,
  output logic [XLEN-1:0]               redirect_addr_o,
  output exu_pkg::exu_trap_e            trap_o
);

  logic [XLEN-1:0] alu_res;
  logic            jump_flag;
  logic [XLEN-1:0] jump_addr;

  exu_alu #(.XLEN(XLEN)) u_alu (
    .op_i      (op_i),
    .op1_i     (op1_i),
    .op2_i     (op2_i),
    .alu_res_o (alu_res)
  );

  exu_bjp #(.XLEN(XLEN)) u_bjp (
    .op_i        (op_i),
    .op1_i       (op1_i),
    .op2_i       (op2_i),
    .op1_jp_i    (op1_jp_i),
    .op2_jp_i    (op2_jp_i),
    .jump_flag_o (jump_flag),
    .jump_addr_o (jump_addr)
  );

  exu_commit #(.XLEN(XLEN)) u_commit (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .valid_i         (valid_i),
    .op_i            (op_i),
    .rd_wr_en_i      (rd_wr_en_i),
    .rd_idx_i        (rd_idx_i),
    .alu_res_i       (alu_res),
    .jump_flag_i     (jump_flag),
    .jump_addr_i     (jump_addr),
    .out_ready_i     (out_ready_i),
    .ready_o         (ready_o),
    .out_valid_o     (out_valid_o),
    .rd_wr_en_o      (rd_wr_en_o),
    .rd_idx_o        (rd_idx_o),
    .rd_data_o       (rd_data_o),
    .redirect_o      (redirect_o),
    .redirect_addr_o (redirect_addr_o),
    .trap_o          (trap_o)
  );

endmodule

// ==== exu_checker.sv ====
`timescale 1ns/100ps

module exu_checker (
  input logic                          clk,
  input logic                          rst_n_i,
  input logic                          ready_o,
  input logic                          out_ready_i,
  input logic                          out_valid_o,
  input logic                          rd_wr_en_o,
  input logic [4:0]                    rd_idx_o,
  input logic [63:0]                   rd_data_o,
  input logic                          redirect_o,
  input logic [63:0]                   redirect_addr_o,
  input exu_pkg::exu_trap_e            trap_o
);

  // one expected record per accepted input
  logic        q_wen[$];
  logic [4:0]  q_idx[$];
  logic [63:0] q_data[$];
  logic        q_redir[$];
  logic [63:0] q_addr[$];
  logic [1:0]  q_trap[$];
  int          q_cyc[$];

  int errors = 0;
  int checks = 0;
  int cycle  = 0;
  // set by the testbench when latency must be exactly one cycle
  logic strict_lat = 1'b0;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic push(input logic wen, input logic [4:0] idx, input logic [63:0] data,
                      input logic redir, input logic [63:0] addr, input logic [1:0] trap);
    q_wen.push_back(wen);
    q_idx.push_back(idx);
    q_data.push_back(data);
    q_redir.push_back(redir);
    q_addr.push_back(addr);
    q_trap.push_back(trap);
    q_cyc.push_back(cycle);
  endtask

  function automatic int pending();
    return q_wen.size();
  endfunction

  task automatic field_fail(input string name, input logic [63:0] got, input logic [63:0] exp);
    $display("[FAIL] %0t: %s got %h expected %h", $time, name, got, exp);
    errors++;
  endtask

  // sampled at the falling edge where outputs are stable
  always @(negedge clk) begin
    if (rst_n_i && out_valid_o && !out_ready_i && ready_o) begin
      $display("[FAIL] %0t: ready_o high while output is stalled", $time);
      errors++;
    end
    if (rst_n_i && out_valid_o && out_ready_i) begin
      if (q_wen.size() == 0) begin
        $display("output delivered at %0t with no input waiting for it", $time);
        errors++;
      end else begin
        checks++;
        if (rd_wr_en_o !== q_wen[0]) field_fail("rd_wr_en", 64'(rd_wr_en_o), 64'(q_wen[0]));
        if (rd_idx_o !== q_idx[0]) field_fail("rd_idx", 64'(rd_idx_o), 64'(q_idx[0]));
        if (rd_data_o !== q_data[0]) field_fail("rd_data", rd_data_o, q_data[0]);
        if (redirect_o !== q_redir[0]) field_fail("redirect", 64'(redirect_o), 64'(q_redir[0]));
        if (redirect_addr_o !== q_addr[0]) field_fail("redirect_addr", redirect_addr_o, q_addr[0]);
        if (trap_o !== q_trap[0]) field_fail("trap", 64'(trap_o), 64'(q_trap[0]));
        if (strict_lat && (cycle != q_cyc[0] + 1)) begin
          $display("[FAIL] %0t: latency %0d cycles instead of 1", $time, cycle - q_cyc[0]);
          errors++;
        end
        void'(q_wen.pop_front());
        void'(q_idx.pop_front());
        void'(q_data.pop_front());
        void'(q_redir.pop_front());
        void'(q_addr.pop_front());
        void'(q_trap.pop_front());
        void'(q_cyc.pop_front());
      end
    end
  end

endmodule

// ==== exu_tb.sv ====
`timescale 1ns/100ps

module exu_tb;

  localparam int N_ALU  = 8;
  localparam int N_BR   = 8;
  localparam int N_BP   = 60;
  localparam int N_TP   = 20;
  localparam int N_ALL  = 11 * N_ALU + 4 + 8 * N_BR + 13 + N_BP + N_TP;
  localparam time LIMIT = (N_ALL * 4 + 3) * 100ns;
  // cycles to wait for outstanding records at the end of a test
  localparam int DRAIN_MAX = 64;

  logic             clk;
  logic             rst_n_i;
  logic             valid_i;
  exu_pkg::exu_op_e op_i;
  logic             rd_wr_en_i;
  logic [4:0]       rd_idx_i;
  logic [63:0]      op1_i;
  logic [63:0]      op2_i;
  logic [63:0]      op1_jp_i;
  logic [63:0]      op2_jp_i;
  logic             out_ready_i;
  logic             ready_o;
  logic             out_valid_o;
  logic             rd_wr_en_o;
  logic [4:0]       rd_idx_o;
  logic [63:0]      rd_data_o;
  logic             redirect_o;
  logic [63:0]      redirect_addr_o;
  exu_pkg::exu_trap_e trap_o;

  integer seed    = 32'h61c6;
  integer bp_seed = 32'h61c6 ^ 32'h1;
  logic   bp_on      = 1'b0;
  logic   expect_rdy = 1'b0;
  int     tb_errors  = 0;
  int     err_mark;
  int     chk_mark;

  exu_top #(.XLEN(64)) DUT (.*);

  exu_checker u_checker (
    .clk(clk), .rst_n_i(rst_n_i), .ready_o(ready_o),
    .out_ready_i(out_ready_i), .out_valid_o(out_valid_o), .rd_wr_en_o(rd_wr_en_o),
    .rd_idx_o(rd_idx_o), .rd_data_o(rd_data_o), .redirect_o(redirect_o),
    .redirect_addr_o(redirect_addr_o), .trap_o(trap_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    #(LIMIT);
    $display("watchdog expired, the run did not finish in time");
    $display("Done: errors found");
    $finish;
  end

  // random consumer stalls only during the back-pressure test
  initial begin
    logic [31:0] r;
    forever begin
      @(posedge clk);
      #1;
      r = $random(bp_seed);
      out_ready_i = bp_on ? r[0] : 1'b1;
    end
  end

  // expected record from the RV64I rules
  function automatic void ref_model(input logic [4:0] code, input logic wen,
      input logic [63:0] a, input logic [63:0] b, input logic [63:0] ja,
      input logic [63:0] jb, output logic e_wen, output logic [63:0] e_data,
      output logic e_redir, output logic [63:0] e_addr, output logic [1:0] e_trap);
    logic [5:0] sh;
    sh = b[5:0];
    e_data = 64'd0;
    e_redir = 1'b0;
    case (code)
      5'd0:  e_data = a + b;
      5'd1:  e_data = a - b;
      5'd2:  e_data = a << sh;
      5'd3:  e_data = {63'd0, $signed(a) < $signed(b)};
      5'd4:  e_data = {63'd0, a < b};
      5'd5:  e_data = a ^ b;
      5'd6:  e_data = a >> sh;
      5'd7:  e_data = $signed(a) >>> sh;
      5'd8:  e_data = a | b;
      5'd9:  e_data = a & b;
      5'd10: e_data = b;
      5'd11, 5'd12: begin
        e_data = a + b;
        e_redir = 1'b1;
      end
      5'd13: e_redir = (a == b);
      5'd14: e_redir = (a != b);
      5'd15: e_redir = $signed(a) < $signed(b);
      5'd16: e_redir = $signed(a) >= $signed(b);
      5'd17: e_redir = a < b;
      5'd18: e_redir = a >= b;
      default: e_data = 64'd0;
    endcase
    e_addr = ja + jb;
    if (code == 5'd12) e_addr[0] = 1'b0;
    e_trap = (code == 5'd19) ? 2'd1 : (code > 5'd19) ? 2'd2 : 2'd0;
    e_wen = wen && (code <= 5'd12);
  endfunction

  task automatic send(input logic [4:0] code, input logic [63:0] a, input logic [63:0] b,
                      input logic [63:0] ja, input logic [63:0] jb);
    logic        accepted;
    logic        e_wen;
    logic [63:0] e_data;
    logic        e_redir;
    logic [63:0] e_addr;
    logic [1:0]  e_trap;
    logic [31:0] r;
    r = $random(seed);
    op_i = exu_pkg::exu_op_e'(code);
    rd_wr_en_i = r[0];
    rd_idx_i = r[5:1];
    op1_i = a;
    op2_i = b;
    op1_jp_i = ja;
    op2_jp_i = jb;
    valid_i = 1'b1;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      if (ready_o) begin
        accepted = 1'b1;
        ref_model(code, rd_wr_en_i, a, b, ja, jb, e_wen, e_data, e_redir, e_addr, e_trap);
        u_checker.push(e_wen, rd_idx_i, e_data, e_redir, e_addr, e_trap);
      end else if (expect_rdy) begin
        $display("ready_o dropped at %0t while the output was never stalled", $time);
        tb_errors++;
      end
      @(posedge clk);
      #1;
    end
    valid_i = 1'b0;
  endtask

  function automatic logic [63:0] rnd64();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic drain();
    int waited;
    waited = 0;
    while (u_checker.pending() != 0 && waited < DRAIN_MAX) begin
      @(negedge clk);
      waited++;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic begin_test();
    err_mark = u_checker.errors + tb_errors;
    chk_mark = u_checker.checks;
  endtask

  task automatic end_test(input string name);
    drain();
    $display("test %s: %0d records checked, %0d errors", name,
             u_checker.checks - chk_mark, u_checker.errors + tb_errors - err_mark);
  endtask

  initial begin
    logic [63:0] a;
    logic [63:0] b;
    valid_i = 1'b0;
    op_i = exu_pkg::OP_ADD;
    rd_wr_en_i = 1'b0;
    rd_idx_i = 5'd0;
    op1_i = 64'd0;
    op2_i = 64'd0;
    op1_jp_i = 64'd0;
    op2_jp_i = 64'd0;
    out_ready_i = 1'b1;
    rst_n_i = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_n_i = 1'b1;

    begin_test();
    @(negedge clk);
    if (out_valid_o !== 1'b0 || redirect_o !== 1'b0 || trap_o !== exu_pkg::TRAP_NONE) begin
      $display("outputs not idle after reset at %0t", $time);
      tb_errors++;
    end
    @(posedge clk);
    #1;
    end_test("reset");

    begin_test();
    for (int op = 0; op <= 10; op++) begin
      for (int i = 0; i < N_ALU; i++) begin
        a = rnd64();
        b = (i == 0) ? a : rnd64();
        send(5'(op), a, b, rnd64(), rnd64());
      end
    end
    // arithmetic shift of a negative value at the edge amounts
    send(5'd7, 64'h8000_0000_0000_0001, 64'd0, 64'd0, 64'd0);
    send(5'd7, 64'h8000_0000_0000_0001, 64'd63, 64'd0, 64'd0);
    send(5'd7, 64'hf0f0_0000_1234_5678, 64'd63, 64'd0, 64'd0);
    send(5'd4, 64'hffff_ffff_ffff_ffff, 64'd1, 64'd0, 64'd0);
    end_test("alu_ops");

    begin_test();
    for (int op = 11; op <= 18; op++) begin
      for (int i = 0; i < N_BR; i++) begin
        a = rnd64();
        b = (i < 2) ? a : rnd64();
        if (op <= 12) b = 64'd4;
        send(5'(op), a, b, rnd64(), rnd64());
      end
    end
    end_test("branch_jump");

    begin_test();
    for (int op = 19; op <= 31; op++) begin
      send(5'(op), rnd64(), rnd64(), rnd64(), rnd64());
    end
    end_test("traps");

    begin_test();
    bp_on = 1'b1;
    for (int i = 0; i < N_BP; i++) begin
      send(5'($unsigned($random(seed)) % 32), rnd64(), rnd64(), rnd64(), rnd64());
    end
    drain();
    bp_on = 1'b0;
    end_test("back_pressure");

    begin_test();
    // let the consumer driver settle to always ready
    repeat (2) @(posedge clk);
    #1;
    u_checker.strict_lat = 1'b1;
    expect_rdy = 1'b1;
    for (int i = 0; i < N_TP; i++) begin
      send(5'(i % 19), rnd64(), rnd64(), rnd64(), rnd64());
    end
    expect_rdy = 1'b0;
    end_test("throughput");

    if (u_checker.pending() != 0) begin
      $display("%0d expected records were never delivered", u_checker.pending());
      tb_errors++;
    end
    $display("checks: %0d, errors: %0d", u_checker.checks, u_checker.errors + tb_errors);
    if (u_checker.errors + tb_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== exu.f ====
exu_pkg.sv
exu_alu.sv
exu_bjp.sv
exu_pipe_reg.sv
exu_commit.sv
exu_top.sv
exu_checker.sv
exu_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -f exu.f --top-module exu_tb -o exu_sim

out=$(./obj_dir/exu_sim)
echo "$out"

if echo "$out" | grep -q "^Done: no errors$"; then
  exit 0
else
  exit 1
fi
